//--- hdl/aud_pkg.sv
`default_nettype none

package aud_pkg;

    // sender states, in the order the controller steps through them.
    typedef enum logic [1:0] {
        S_IDLE  = 2'd0,
        S_WAIT  = 2'd1,
        S_DELAY = 2'd2,
        S_SEND  = 2'd3
    } aud_state_e;

    localparam int TPLAY_W = 6; // seconds count, wraps at 63.

    localparam int DEF_DATA_W        = 16;
    localparam int DEF_FIFO_DEPTH    = 8;
    localparam int DEF_TICKS_PER_SEC = 12_000_000; // bit clocks per second.

endpackage

`default_nettype wire

//--- hdl/aud_sample_fifo.sv
`default_nettype none

module aud_sample_fifo #(
    parameter int DATA_W     = 16,
    parameter int FIFO_DEPTH = 8
) (
    input  wire logic              i_bclk,
    input  wire logic              i_rst_n,
    input  wire logic              i_wr,
    input  wire logic [DATA_W-1:0] i_wdata,
    input  wire logic              i_rd,
    output logic      [DATA_W-1:0] o_rdata,
    output logic                   o_empty,
    output logic                   o_full
);

    localparam int ADDR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W  = $clog2(FIFO_DEPTH + 1);

    localparam logic [ADDR_W-1:0] PTR_LAST  = ADDR_W'(FIFO_DEPTH - 1);
    localparam logic [CNT_W-1:0]  CNT_DEPTH = CNT_W'(FIFO_DEPTH);

    logic [DATA_W-1:0] mem [FIFO_DEPTH];
    logic [ADDR_W-1:0] wr_ptr_q;
    logic [ADDR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0]  count_q;
    logic              wr_ok;
    logic              rd_ok;

    assign wr_ok = i_wr & ~o_full;  // writes while full are dropped.
    assign rd_ok = i_rd & ~o_empty;

    assign o_empty = (count_q == '0);
    assign o_full  = (count_q == CNT_DEPTH);
    assign o_rdata = mem[rd_ptr_q]; // head is shown, valid with the pop.

    always_ff @(posedge i_bclk) begin
        if (wr_ok) begin
            mem[wr_ptr_q] <= i_wdata;
        end
    end

    always_ff @(posedge i_bclk) begin
        if (!i_rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
            end
            // simultaneous write and pop leave the count unchanged.
            case ({wr_ok, rd_ok})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/aud_dac_shifter.sv
`default_nettype none

module aud_dac_shifter #(
    parameter int DATA_W = 16
) (
    input  wire logic              i_bclk,
    input  wire logic              i_rst_n,
    input  wire logic              i_load,
    input  wire logic              i_zero,
    input  wire logic [DATA_W-1:0] i_data,
    input  wire logic              i_shift,
    output logic                   o_dacdat
);

    logic [DATA_W-1:0] shreg_q;
    logic              dacdat_q;

    assign o_dacdat = dacdat_q;

    // holds the sample being sent.
    always_ff @(posedge i_bclk) begin
        if (i_load) begin
            shreg_q <= i_zero ? '0 : i_data; // silent frame on underrun.
        end else if (i_shift) begin
            shreg_q <= {shreg_q[DATA_W-2:0], 1'b0};
        end
    end

    // output bit is held low outside the send window.
    always_ff @(posedge i_bclk) begin
        if (!i_rst_n) begin
            dacdat_q <= 1'b0;
        end else if (i_shift) begin
            dacdat_q <= shreg_q[DATA_W-1]; // msb first.
        end else begin
            dacdat_q <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hdl/aud_play_timer.sv
`default_nettype none

module aud_play_timer import aud_pkg::*; #(
    parameter int TICKS_PER_SEC = 12_000_000
) (
    input  wire logic               i_bclk,
    input  wire logic               i_rst_n,
    input  wire logic               i_run,
    output logic      [TPLAY_W-1:0] o_tplay
);

    localparam int TICK_W = (TICKS_PER_SEC > 1) ? $clog2(TICKS_PER_SEC) : 1;

    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(TICKS_PER_SEC - 1);

    logic [TICK_W-1:0]  tick_q;
    logic [TPLAY_W-1:0] tplay_q;
    logic               sec_done;

    assign sec_done = (tick_q == TICK_LAST);
    assign o_tplay  = tplay_q;

    always_ff @(posedge i_bclk) begin
        if (!i_rst_n) begin
            tick_q  <= '0;
            tplay_q <= '0;
        end else if (i_run) begin
            if (sec_done) begin
                tick_q  <= '0;
                tplay_q <= tplay_q + 1'b1; // wraps 63 -> 0.
            end else begin
                tick_q <= tick_q + 1'b1;
            end
        end
        // both counts hold while paused.
    end

endmodule

`default_nettype wire

//--- hdl/aud_play_ctrl.sv
`default_nettype none

module aud_play_ctrl import aud_pkg::*; #(
    parameter int DATA_W = 16
) (
    input  wire logic i_bclk,
    input  wire logic i_rst_n,
    input  wire logic i_daclrck,
    input  wire logic i_en,
    input  wire logic i_empty,
    output logic      o_pop,
    output logic      o_load,
    output logic      o_zero,
    output logic      o_shift,
    output logic      o_sent_finished,
    output logic      o_underrun
);

    localparam int CNT_W = $clog2(DATA_W + 1);

    localparam logic [CNT_W-1:0] CNT_DONE = CNT_W'(DATA_W);

    aud_state_e       state_q;
    aud_state_e       state_d;
    logic             lrck_q;
    logic             frame_start;
    logic [CNT_W-1:0] cnt_q;
    logic             zero_q;
    logic             finished_q;
    logic             underrun_q;
    logic             send_done;

    // left channel begins when lrck goes low.
    assign frame_start = lrck_q & ~i_daclrck;
    assign send_done   = (state_q == S_SEND) && (cnt_q == CNT_DONE);

    assign o_load  = (state_q == S_DELAY);
    assign o_zero  = o_load & i_empty;
    assign o_pop   = o_load & ~i_empty;
    assign o_shift = (state_q == S_SEND) && (cnt_q != CNT_DONE);

    assign o_sent_finished = finished_q;
    assign o_underrun      = underrun_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (i_en) begin
                    state_d = S_WAIT;
                end
            end
            S_WAIT: begin
                if (!i_en) begin
                    state_d = S_IDLE;
                end else if (frame_start) begin
                    state_d = S_DELAY;
                end
            end
            S_DELAY: state_d = S_SEND; // one-bit i2s delay.
            S_SEND: begin
                if (send_done) begin
                    state_d = i_en ? S_WAIT : S_IDLE;
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge i_bclk) begin
        if (!i_rst_n) begin
            state_q    <= S_IDLE;
            lrck_q     <= 1'b0;
            cnt_q      <= '0;
            zero_q     <= 1'b0;
            finished_q <= 1'b0;
            underrun_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            lrck_q     <= i_daclrck;
            finished_q <= send_done & ~zero_q;
            underrun_q <= send_done & zero_q;
            if (o_load) begin
                cnt_q  <= '0;
                zero_q <= i_empty; // remembered for the closing pulse.
            end else if (o_shift) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/aud_player_top.sv
`default_nettype none

module aud_player_top import aud_pkg::*; #(
    parameter int DATA_W        = DEF_DATA_W,
    parameter int FIFO_DEPTH    = DEF_FIFO_DEPTH,
    parameter int TICKS_PER_SEC = DEF_TICKS_PER_SEC
) (
    input  wire logic               i_bclk,
    input  wire logic               i_rst_n,
    input  wire logic               i_daclrck,
    input  wire logic               i_en,
    input  wire logic               i_sample_wr,
    input  wire logic [DATA_W-1:0]  i_sample,
    output logic                    o_aud_dacdat,
    output logic                    o_sent_finished,
    output logic                    o_underrun,
    output logic                    o_full,
    output logic      [TPLAY_W-1:0] o_tplay
);

    logic              fifo_pop;
    logic              fifo_empty;
    logic [DATA_W-1:0] fifo_rdata;
    logic              sh_load;
    logic              sh_zero;
    logic              sh_shift;

    aud_sample_fifo #(
        .DATA_W     (DATA_W),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_fifo (
        .i_bclk  (i_bclk),
        .i_rst_n (i_rst_n),
        .i_wr    (i_sample_wr),
        .i_wdata (i_sample),
        .i_rd    (fifo_pop),
        .o_rdata (fifo_rdata),
        .o_empty (fifo_empty),
        .o_full  (o_full)
    );

    aud_dac_shifter #(
        .DATA_W (DATA_W)
    ) i_shifter (
        .i_bclk   (i_bclk),
        .i_rst_n  (i_rst_n),
        .i_load   (sh_load),
        .i_zero   (sh_zero),
        .i_data   (fifo_rdata),
        .i_shift  (sh_shift),
        .o_dacdat (o_aud_dacdat)
    );

    // play time runs with the enable level.
    aud_play_timer #(
        .TICKS_PER_SEC (TICKS_PER_SEC)
    ) i_timer (
        .i_bclk  (i_bclk),
        .i_rst_n (i_rst_n),
        .i_run   (i_en),
        .o_tplay (o_tplay)
    );

    aud_play_ctrl #(
        .DATA_W (DATA_W)
    ) i_ctrl (
        .i_bclk          (i_bclk),
        .i_rst_n         (i_rst_n),
        .i_daclrck       (i_daclrck),
        .i_en            (i_en),
        .i_empty         (fifo_empty),
        .o_pop           (fifo_pop),
        .o_load          (sh_load),
        .o_zero          (sh_zero),
        .o_shift         (sh_shift),
        .o_sent_finished (o_sent_finished),
        .o_underrun      (o_underrun)
    );

endmodule

`default_nettype wire

//--- verif/aud_player_asserts.sv
`default_nettype none

module aud_player_asserts
    import aud_pkg::*;
(
    input wire logic               i_bclk,
    input wire logic               i_rst_n,
    input wire logic               i_daclrck,
    input wire logic               i_en,
    input wire logic               i_dacdat,
    input wire logic               i_sent_finished,
    input wire logic               i_underrun,
    input wire logic [TPLAY_W-1:0] i_tplay,
    input wire aud_state_e         i_state
);

    int n_fail = 0;

    a_right_silent: assert property (
        @(posedge i_bclk) disable iff (!i_rst_n) i_daclrck |-> !i_dacdat
    ) else begin
        n_fail++;
        $error("serial data high while daclrck is high");
    end

    // a set bit can only come out of the send state.
    a_data_in_send: assert property (
        @(posedge i_bclk) disable iff (!i_rst_n) i_dacdat |-> (i_state == S_SEND)
    ) else begin
        n_fail++;
        $error("serial data high outside the send state");
    end

    a_finished_single: assert property (
        @(posedge i_bclk) disable iff (!i_rst_n) i_sent_finished |=> !i_sent_finished
    ) else begin
        n_fail++;
        $error("sent finished pulse longer than one cycle");
    end

    a_underrun_single: assert property (
        @(posedge i_bclk) disable iff (!i_rst_n) i_underrun |=> !i_underrun
    ) else begin
        n_fail++;
        $error("underrun pulse longer than one cycle");
    end

    a_tplay_hold: assert property (
        @(posedge i_bclk) disable iff (!i_rst_n) !i_en |=> $stable(i_tplay)
    ) else begin
        n_fail++;
        $error("play time moved while playback was disabled");
    end

    // steps by one and wraps from 63 to 0.
    a_tplay_step: assert property (
        @(posedge i_bclk) disable iff (!i_rst_n)
            $changed(i_tplay) |-> (i_tplay == TPLAY_W'($past(i_tplay) + 1'b1))
    ) else begin
        n_fail++;
        $error("play time did not advance by one second");
    end

    a_reset_values: assert property (
        @(posedge i_bclk) $rose(i_rst_n) |->
            (i_tplay == '0) && !i_dacdat && !i_sent_finished && !i_underrun
            && (i_state == S_IDLE)
    ) else begin
        n_fail++;
        $error("outputs or state not at their reset values");
    end

endmodule

`default_nettype wire

//--- verif/tb_aud_player.sv
`default_nettype none

module tb_aud_player
    import aud_pkg::*;
();

    localparam int DATA_W        = DEF_DATA_W;
    localparam int FIFO_DEPTH    = DEF_FIFO_DEPTH;
    localparam int TICKS_PER_SEC = 200;
    localparam int N_FRAMES      = 240;
    localparam int MAX_CYCLES    = N_FRAMES * 64 + 2000;

    logic               i_bclk;
    logic               i_rst_n;
    logic               i_daclrck;
    logic               i_en;
    logic               i_sample_wr;
    logic [DATA_W-1:0]  i_sample;
    logic               o_aud_dacdat;
    logic               o_sent_finished;
    logic               o_underrun;
    logic               o_full;
    logic [TPLAY_W-1:0] o_tplay;

    logic [DATA_W-1:0] ref_q [$];
    logic [DATA_W-1:0] exp_word;
    logic [DATA_W-1:0] got_word;
    logic              exp_zero;
    logic              wr_ok;
    logic              lrck_prev;
    logic [31:0]       rng = 32'he04b_4593;
    int                pos = -1;
    int                tick = 0;
    int                secs = 0;
    int                cycles = 0;
    int                n_errors = 0;
    int                total;

    aud_player_top #(
        .DATA_W        (DATA_W),
        .FIFO_DEPTH    (FIFO_DEPTH),
        .TICKS_PER_SEC (TICKS_PER_SEC)
    ) i_dut (
        .i_bclk          (i_bclk),
        .i_rst_n         (i_rst_n),
        .i_daclrck       (i_daclrck),
        .i_en            (i_en),
        .i_sample_wr     (i_sample_wr),
        .i_sample        (i_sample),
        .o_aud_dacdat    (o_aud_dacdat),
        .o_sent_finished (o_sent_finished),
        .o_underrun      (o_underrun),
        .o_full          (o_full),
        .o_tplay         (o_tplay)
    );

    bind aud_player_top aud_player_asserts i_asserts (
        .i_bclk          (i_bclk),
        .i_rst_n         (i_rst_n),
        .i_daclrck       (i_daclrck),
        .i_en            (i_en),
        .i_dacdat        (o_aud_dacdat),
        .i_sent_finished (o_sent_finished),
        .i_underrun      (o_underrun),
        .i_tplay         (o_tplay),
        .i_state         (i_ctrl.state_q)
    );

    function automatic logic [31:0] next_rand(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic void check_value(string what, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            n_errors++;
            $display("error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endfunction

    // one-cycle strobe with a gap after it.
    task automatic write_sample();
        rng = next_rand(rng);
        i_sample_wr = 1'b1;
        i_sample    = rng[DATA_W-1:0];
        @(negedge i_bclk);
        i_sample_wr = 1'b0;
        @(negedge i_bclk);
    endtask

    initial begin
        i_bclk = 1'b0;
        forever #20 i_bclk = ~i_bclk;
    end

    // codec frame clock, each half is 32 bit clocks.
    initial begin
        i_daclrck = 1'b1;
        forever begin
            repeat (32) @(negedge i_bclk);
            i_daclrck = ~i_daclrck;
        end
    end

    always @(posedge i_bclk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // reference model, sees the values from just before the edge.
    always @(posedge i_bclk) begin
        if (!i_rst_n) begin
            ref_q.delete();
            lrck_prev = 1'b0;
            pos       = -1;
            tick      = 0;
            secs      = 0;
        end else begin
            wr_ok = i_sample_wr && (ref_q.size() < FIFO_DEPTH);
            if (pos >= 0) begin
                pos++;
            end
            check_value("o_tplay", o_tplay, secs);
            check_value("o_full", o_full, ref_q.size() == FIFO_DEPTH);
            if (pos == 1) begin // pop edge.
                exp_zero = (ref_q.size() == 0);
                got_word = '0;
                if (exp_zero) begin
                    exp_word = '0;
                end else begin
                    exp_word = ref_q.pop_front();
                end
            end
            if (pos >= 3 && pos <= DATA_W + 2) begin
                got_word = {got_word[DATA_W-2:0], o_aud_dacdat};
            end else begin
                check_value("o_aud_dacdat outside send", o_aud_dacdat, 0);
            end
            if (pos == DATA_W + 3) begin
                check_value("sample word", got_word, exp_word);
                check_value("o_sent_finished", o_sent_finished, !exp_zero);
                check_value("o_underrun", o_underrun, exp_zero);
                pos = -1;
            end else begin
                check_value("o_sent_finished", o_sent_finished, 0);
                check_value("o_underrun", o_underrun, 0);
            end
            if (wr_ok) begin
                ref_q.push_back(i_sample);
            end
            if (pos < 0 && i_en && lrck_prev && !i_daclrck) begin
                pos = 0; // frame start.
            end
            if (i_en) begin
                if (tick == TICKS_PER_SEC - 1) begin
                    tick = 0;
                    secs = (secs == (1 << TPLAY_W) - 1) ? 0 : secs + 1;
                end else begin
                    tick++;
                end
            end
            lrck_prev = i_daclrck;
        end
    end

    initial begin
        i_rst_n     = 1'b0;
        i_en        = 1'b0;
        i_sample_wr = 1'b0;
        i_sample    = '0;
        repeat (10) @(negedge i_bclk);
        i_rst_n = 1'b1;

        // enable changes land in the right half, away from frame starts.
        for (int f = 0; f < N_FRAMES; f++) begin
            @(posedge i_daclrck);
            repeat (4) @(negedge i_bclk);
            if (f == 0) begin
                repeat (FIFO_DEPTH + 1) write_sample(); // last one is dropped.
                check_value("o_full after fill", o_full, 1);
            end else if (f == 2 || f == 103 || f == 152) begin
                i_en = 1'b1;
            end else if (f == 100) begin
                i_en = 1'b0;
            end else if (f == 150) begin
                @(negedge i_daclrck);
                repeat (8) @(negedge i_bclk);
                i_en = 1'b0; // mid-frame, the sample still completes.
            end else if (f > 12) begin
                rng = next_rand(rng);
                if (rng[1:0] != 2'd0) begin
                    write_sample();
                end
                if (rng[1:0] == 2'd3) begin
                    write_sample();
                end
            end
        end

        repeat (2) @(posedge i_daclrck);
        @(negedge i_bclk);
        total = n_errors + i_dut.i_asserts.n_fail;
        $display("compare errors: %0d, assertion failures: %0d",
                 n_errors, i_dut.i_asserts.n_fail);
        if (total == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- aud_player_top.f
hdl/aud_pkg.sv
hdl/aud_sample_fifo.sv
hdl/aud_dac_shifter.sv
hdl/aud_play_timer.sv
hdl/aud_play_ctrl.sv
hdl/aud_player_top.sv
verif/aud_player_asserts.sv
verif/tb_aud_player.sv

//--- Bender.yml
package:
  name: aud_player

sources:
  - files:
      - hdl/aud_pkg.sv
      - hdl/aud_sample_fifo.sv
      - hdl/aud_dac_shifter.sv
      - hdl/aud_play_timer.sv
      - hdl/aud_play_ctrl.sv
      - hdl/aud_player_top.sv
  - target: test
    files:
      - verif/aud_player_asserts.sv
      - verif/tb_aud_player.sv
